//--- project.f
design/img_pkg.sv
design/grad_pkg.sv
design/frame_reader.sv
design/window_buffer.sv
design/grad_unit.sv
design/ig_top.sv
sim/tb_clock.sv
sim/tb_ig.sv

//--- Bender.yml
package:
  name: image_gradient

sources:
  # packages first, then the design
  - design/img_pkg.sv
  - design/grad_pkg.sv
  - design/frame_reader.sv
  - design/window_buffer.sv
  - design/grad_unit.sv
  - design/ig_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_ig.sv

//--- sim/tb_ig.sv
module tb_ig;

    localparam int          clk_period      = 8;
    localparam logic [31:0] seed            = 32'hf48c;
    localparam int          expected_writes = 65025;
    localparam int          mid_reset_cycle = 1000;
    localparam longint      watchdog_limit  =
        longint'(img_pkg::frame_pixels) * 5 / 2 * clk_period;

    // error classes
    localparam int err_read   = 0;
    localparam int err_data   = 1;
    localparam int err_cover  = 2;
    localparam int err_timing = 3;
    localparam int err_done   = 4;

    // one issued read, as seen on the image port
    typedef struct packed {
        logic               rd;
        img_pkg::img_addr_t addr;
    } read_tag_t;

    logic                 clk;
    logic                 reset_init;
    logic                 reset_mid;
    logic                 reset;
    logic                 img_rd;
    img_pkg::img_addr_t   img_addr;
    img_pkg::pixel_t      img_di;
    logic                 grad_wr;
    img_pkg::img_addr_t   grad_addr;
    grad_pkg::grad_word_t grad_do;
    logic                 done;

    img_pkg::pixel_t      image [img_pkg::frame_pixels];
    grad_pkg::grad_word_t grad_mem [img_pkg::frame_pixels];
    int                   wr_seen [img_pkg::frame_pixels];

    logic      armed = 1'b0;
    int        run_cycle = 0;
    int        writes_total = 0;
    read_tag_t read_hist [3];
    int        err_count [5] = '{default: 0};

    logic               exp_rd;
    img_pkg::img_addr_t exp_addr;
    logic               exp_wr;
    img_pkg::img_addr_t exp_grad_addr;
    logic               exp_done;

    assign reset = reset_init | reset_mid;

    tb_clock clock_i (
        .clk   (clk),
        .reset (reset_init)
    );

    ig_top ig_top_i (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // gx and gy straight from the image, signed, kept to 10 bits
    function automatic grad_pkg::grad_word_t expected_word(input img_pkg::img_addr_t addr);
        int origin;
        int right;
        int below;
        int gx;
        int gy;
        origin = image[int'(addr)];
        right  = image[int'(addr) + 1];
        below  = image[int'(addr) + img_pkg::img_width];
        gx     = right - origin;
        gy     = below - origin;
        return {gx[9:0], gy[9:0]};
    endfunction

    function automatic int total_errors();
        int sum;
        sum = 0;
        foreach (err_count[i]) begin
            sum += err_count[i];
        end
        return sum;
    endfunction

    task automatic record_mismatch(input int kind, input string name,
                                   input logic [31:0] expected, input logic [31:0] actual);
        err_count[kind]++;
        $display("[FAIL] %0t %s: expected %0h, actual %0h", $time, name, expected, actual);
    endtask

    task automatic record_problem(input int kind, input string what);
        err_count[kind]++;
        $display("error at time %0t: %s", $time, what);
    endtask

    task automatic fill_image();
        logic [31:0] state;
        state = seed;
        for (int a = 0; a < img_pkg::frame_pixels; a++) begin
            state    = next_random(state);
            image[a] = state[23:16];
        end
    endtask

    // every inner address once with the right word, border never
    task automatic check_final_state();
        int col;
        int row;
        int want;
        for (int a = 0; a < img_pkg::frame_pixels; a++) begin
            col  = a % img_pkg::img_width;
            row  = a / img_pkg::img_width;
            want = (col < img_pkg::img_width - 1 && row < img_pkg::img_height - 1) ? 1 : 0;
            assert (wr_seen[a] == want)
                else record_mismatch(err_cover, $sformatf("write count at %0h", a),
                                     want, wr_seen[a]);
            if (want == 1) begin
                assert (grad_mem[a] == expected_word(img_pkg::img_addr_t'(a)))
                    else record_mismatch(err_data, $sformatf("stored word at %0h", a),
                                         expected_word(img_pkg::img_addr_t'(a)), grad_mem[a]);
            end
        end
        assert (writes_total == expected_writes)
            else record_mismatch(err_cover, "write total", expected_writes, writes_total);
    endtask

    // ------------------------------
    // memory models and tracking
    // ------------------------------

    // image memory answers one cycle after the read
    always @(posedge clk) begin
        if (img_rd) begin
            img_di <= image[img_addr];
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            run_cycle    <= 0;
            writes_total <= 0;
            for (int i = 0; i < 3; i++) begin
                read_hist[i] <= '0;
            end
            for (int a = 0; a < img_pkg::frame_pixels; a++) begin
                wr_seen[a] <= 0;
            end
        end else begin
            // outputs are defined once the first reset has been released
            armed             <= 1'b1;
            run_cycle         <= run_cycle + 1;
            read_hist[0].rd   <= img_rd;
            read_hist[0].addr <= img_addr;
            read_hist[1]      <= read_hist[0];
            read_hist[2]      <= read_hist[1];
            if (grad_wr) begin
                grad_mem[grad_addr] <= grad_do;
                wr_seen[grad_addr]  <= wr_seen[grad_addr] + 1;
                writes_total        <= writes_total + 1;
            end
        end
    end

    assign exp_rd   = (run_cycle >= 1) && (run_cycle <= img_pkg::frame_pixels);
    assign exp_addr = img_pkg::img_addr_t'(run_cycle - 1);
    // pixel (x+1, y+1) read three cycles ago closes origin (x, y)
    assign exp_wr   = read_hist[2].rd &&
                      (read_hist[2].addr % img_pkg::img_width != 0) &&
                      (read_hist[2].addr / img_pkg::img_width != 0);
    assign exp_grad_addr = img_pkg::img_addr_t'(read_hist[2].addr - img_pkg::img_width - 1);
    assign exp_done = (writes_total == expected_writes);

    // ------------------------------
    // checks
    // ------------------------------
    rd_level: assert property (@(posedge clk) disable iff (!armed) img_rd == exp_rd)
        else record_mismatch(err_read, "img_rd", $sampled(exp_rd), $sampled(img_rd));

    rd_addr: assert property (@(posedge clk) disable iff (!armed)
                              img_rd |-> img_addr == exp_addr)
        else record_mismatch(err_read, "img_addr", $sampled(exp_addr), $sampled(img_addr));

    wr_data: assert property (@(posedge clk) disable iff (!armed)
                              grad_wr |-> grad_do == expected_word(grad_addr))
        else record_mismatch(err_data, "grad_do", expected_word($sampled(grad_addr)),
                             $sampled(grad_do));

    wr_inside: assert property (@(posedge clk) disable iff (!armed)
                                grad_wr |->
                                (grad_addr % img_pkg::img_width < img_pkg::img_width - 1) &&
                                (grad_addr / img_pkg::img_width < img_pkg::img_height - 1))
        else record_problem(err_cover,
                            $sformatf("write to border address %0h", $sampled(grad_addr)));

    wr_once: assert property (@(posedge clk) disable iff (!armed)
                              grad_wr |-> wr_seen[grad_addr] == 0)
        else record_problem(err_cover,
                            $sformatf("address %0h written twice", $sampled(grad_addr)));

    wr_timing: assert property (@(posedge clk) disable iff (!armed) grad_wr == exp_wr)
        else record_mismatch(err_timing, "grad_wr", $sampled(exp_wr), $sampled(grad_wr));

    wr_addr: assert property (@(posedge clk) disable iff (!armed)
                              grad_wr |-> grad_addr == exp_grad_addr)
        else record_mismatch(err_timing, "grad_addr", $sampled(exp_grad_addr),
                             $sampled(grad_addr));

    done_level: assert property (@(posedge clk) disable iff (!armed) done == exp_done)
        else record_mismatch(err_done, "done", $sampled(exp_done), $sampled(done));

    reset_clears: assert property (@(posedge clk) disable iff (!armed)
                                   reset |=> (!img_rd && !grad_wr && !done))
        else record_problem(err_done, "img_rd, grad_wr or done still high after reset");

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        reset_mid = 1'b0;
        img_di    = '0;
        fill_image();
        wait (reset_init == 1'b0);

        // let a few rows through, then abandon the frame
        while (run_cycle < mid_reset_cycle) begin
            @(posedge clk);
        end
        reset_mid <= 1'b1;
        repeat (2) @(posedge clk);
        reset_mid <= 1'b0;

        while (!done) begin
            @(posedge clk);
        end
        // done has to hold with both ports idle
        repeat (16) @(posedge clk);
        check_final_state();

        // reset after completion has to clear done
        reset_mid <= 1'b1;
        repeat (2) @(posedge clk);
        reset_mid <= 1'b0;
        repeat (4) @(posedge clk);

        $display("error counts: read %0d, data %0d, coverage %0d, timing %0d, done %0d",
                 err_count[err_read], err_count[err_data], err_count[err_cover],
                 err_count[err_timing], err_count[err_done]);
        if (total_errors() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // two and a half frames of cycles covers the aborted run and a full frame
    initial begin
        #(watchdog_limit);
        $display("timeout: done did not rise within %0d time units", watchdog_limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- sim/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);

    localparam int half_period  = 4;
    localparam int reset_cycles = 5;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
    end

    always #half_period clk = ~clk;

    // release on a rising edge, so the DUT sees reset on five edges
    initial begin
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- design/ig_top.sv
module ig_top (
    input  logic                    clk,
    input  logic                    reset,
    // image memory
    output logic                    img_rd,
    output img_pkg::img_addr_t      img_addr,
    input  img_pkg::pixel_t         img_di,
    // gradient memory
    output logic                    grad_wr,
    output img_pkg::img_addr_t      grad_addr,
    output grad_pkg::grad_word_t    grad_do,
    output logic                    done
);

    // ------------------------------
    // internal streams
    // ------------------------------
    logic                     beat_valid;
    img_pkg::pixel_beat_t     beat;
    logic                     reads_done;
    logic                     win_valid;
    grad_pkg::grad_window_t   win;

    frame_reader frame_reader_i (
        .clk        (clk),
        .reset      (reset),
        .img_rd     (img_rd),
        .img_addr   (img_addr),
        .img_di     (img_di),
        .beat_valid (beat_valid),
        .beat       (beat),
        .reads_done (reads_done)
    );

    // row buffer turns the raster stream into windows
    window_buffer window_buffer_i (
        .clk        (clk),
        .reset      (reset),
        .beat_valid (beat_valid),
        .beat       (beat),
        .win_valid  (win_valid),
        .win        (win)
    );

    grad_unit grad_unit_i (
        .clk        (clk),
        .reset      (reset),
        .win_valid  (win_valid),
        .win        (win),
        .reads_done (reads_done),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .done       (done)
    );

endmodule

//--- design/grad_unit.sv
module grad_unit (
    input  logic                      clk,
    input  logic                      reset,
    // window stream
    input  logic                      win_valid,
    input  grad_pkg::grad_window_t    win,
    input  logic                      reads_done,
    // gradient memory write port
    output logic                      grad_wr,
    output img_pkg::img_addr_t        grad_addr,
    output grad_pkg::grad_word_t      grad_do,
    output logic                      done
);

    grad_pkg::grad_comp_t gx;
    grad_pkg::grad_comp_t gy;

    // writes issued so far in this frame
    img_pkg::img_addr_t wr_count;
    logic               last_written;

    // ------------------------------
    // arithmetic
    // ------------------------------

    // pixels are unsigned, widen with zeros before subtracting
    always_comb begin
        gx = grad_pkg::grad_comp_t'({2'b00, win.right}) -
             grad_pkg::grad_comp_t'({2'b00, win.origin});
        gy = grad_pkg::grad_comp_t'({2'b00, win.below}) -
             grad_pkg::grad_comp_t'({2'b00, win.origin});
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            grad_do   <= {gx, gy};
            grad_addr <= img_pkg::img_addr_t'(win.row * img_pkg::img_width + win.col);
        end
    end

    // ------------------------------
    // write strobe and completion
    // ------------------------------

    // last column and last row have no forward neighbour
    assign last_written = (wr_count == img_pkg::img_addr_t'(
                              (img_pkg::img_width - 1) * (img_pkg::img_height - 1)));

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr  <= 1'b0;
            wr_count <= '0;
        end else begin
            grad_wr <= win_valid;
            if (win_valid) begin
                wr_count <= wr_count + 1'b1;
            end
        end
    end

    // done follows the final write by one cycle and is sticky
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (reads_done && !win_valid && last_written) begin
            done <= 1'b1;
        end
    end

endmodule

//--- design/window_buffer.sv
module window_buffer (
    input  logic                      clk,
    input  logic                      reset,
    // pixel stream in raster order
    input  logic                      beat_valid,
    input  img_pkg::pixel_beat_t      beat,
    // one window per output position
    output logic                      win_valid,
    output grad_pkg::grad_window_t    win
);

    // ------------------------------
    // storage
    // ------------------------------

    // previous row, indexed by column
    img_pkg::pixel_t row_mem [img_pkg::img_width];

    // pixel (x'-1, y') and pixel (x'-1, y'-1) relative to the current beat
    img_pkg::pixel_t prev_cur;
    img_pkg::pixel_t prev_up;

    // pixel (x', y'-1), read before this beat overwrites it
    img_pkg::pixel_t up_here;

    // current beat closes a window when it is not in the first row or column
    logic has_origin;

    assign up_here    = row_mem[beat.col];
    assign has_origin = (beat.col != '0) && (beat.row != '0);

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            row_mem[beat.col] <= beat.pixel;
            prev_cur          <= beat.pixel;
            prev_up           <= up_here;
        end
    end

    // ------------------------------
    // window assembly
    // ------------------------------

    // beat (x', y') completes the window with origin (x'-1, y'-1)
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            win.origin <= prev_up;
            win.right  <= up_here;
            win.below  <= prev_cur;
            win.col    <= beat.col - 1'b1;
            win.row    <= beat.row - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= beat_valid && has_origin;
        end
    end

endmodule

//--- design/frame_reader.sv
module frame_reader (
    input  logic                     clk,
    input  logic                     reset,
    // image memory read port
    output logic                     img_rd,
    output img_pkg::img_addr_t       img_addr,
    input  img_pkg::pixel_t          img_di,
    // tagged pixel stream
    output logic                     beat_valid,
    output img_pkg::pixel_beat_t     beat,
    output logic                     reads_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_reading,
        st_finished
    } state_t;

    state_t state;

    // position of the address issued last cycle
    img_pkg::coord_t tag_col;
    img_pkg::coord_t tag_row;

    // ------------------------------
    // read sequencing
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            img_rd   <= 1'b0;
            img_addr <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // first edge out of reset starts the frame
                    state    <= st_reading;
                    img_rd   <= 1'b1;
                    img_addr <= '0;
                end
                st_reading: begin
                    if (img_addr == img_pkg::img_addr_t'(img_pkg::frame_pixels - 1)) begin
                        state  <= st_finished;
                        img_rd <= 1'b0;
                    end else begin
                        img_addr <= img_addr + 1'b1;
                    end
                end
                st_finished: begin
                    // stay here until the next reset
                    img_rd <= 1'b0;
                end
                default: begin
                    state  <= st_idle;
                    img_rd <= 1'b0;
                end
            endcase
        end
    end

    // ------------------------------
    // return path tagging
    // ------------------------------

    // memory answers one cycle after img_rd
    always_ff @(posedge clk) begin
        if (reset) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= img_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (img_rd) begin
            tag_col <= img_pkg::coord_t'(img_addr % img_pkg::img_width);
            tag_row <= img_pkg::coord_t'(img_addr / img_pkg::img_width);
        end
    end

    always_comb begin
        beat.pixel = img_di;
        beat.col   = tag_col;
        beat.row   = tag_row;
    end

    // every address has been issued
    assign reads_done = (state == st_finished);

endmodule

//--- design/grad_pkg.sv
package grad_pkg;

    // ------------------------------
    // gradient types
    // ------------------------------

    // difference of two 8-bit pixels, needs 9 bits plus headroom
    typedef logic signed [9:0] grad_comp_t;

    // stored word: gx in the upper half, gy in the lower half
    typedef logic [2*$bits(grad_comp_t)-1:0] grad_word_t;

    // ------------------------------
    // three-pixel window
    // ------------------------------

    // origin (x, y), right (x+1, y), below (x, y+1)
    // col and row give the position of the origin
    typedef struct packed {
        img_pkg::pixel_t origin;
        img_pkg::pixel_t right;
        img_pkg::pixel_t below;
        img_pkg::coord_t col;
        img_pkg::coord_t row;
    } grad_window_t;

endpackage

//--- design/img_pkg.sv
package img_pkg;

    // ------------------------------
    // frame geometry
    // ------------------------------
    localparam int img_width    = 256;
    localparam int img_height   = 256;
    localparam int frame_pixels = img_width * img_height;

    // ------------------------------
    // pixel and address types
    // ------------------------------

    // 8-bit unsigned gray value
    typedef logic [7:0] pixel_t;

    // linear address into a frame, row * width + col
    typedef logic [$clog2(frame_pixels)-1:0] img_addr_t;

    // column or row index
    typedef logic [$clog2(img_width)-1:0] coord_t;

    // one pixel as it comes back from the image memory
    typedef struct packed {
        pixel_t pixel;
        coord_t col;
        coord_t row;
    } pixel_beat_t;

endpackage
